// ==== mem_pkg.sv ====
`default_nettype none

package mem_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] uint_x;
    typedef logic [31:0]     addr_t;

    localparam addr_t ADDR_NONE = '1; // no reservation held

    typedef enum logic [1:0] {
        MEN_X,
        MEN_L,
        MEN_S,
        MEN_A  // atomic
    } mem_sel_e;

    // also the write mask code on the bus
    typedef enum logic [1:0] {
        SIZE_B,
        SIZE_H,
        SIZE_W
    } mem_size_e;

    typedef enum logic {
        OP_SIGNED,
        OP_UNSIGNED
    } sign_sel_e;

    typedef enum logic [3:0] {
        ASEL_LR,
        ASEL_SC,
        ASEL_AMO_SWAP,
        ASEL_AMO_ADD,
        ASEL_AMO_XOR,
        ASEL_AMO_AND,
        ASEL_AMO_OR,
        ASEL_AMO_MIN,
        ASEL_AMO_MAX
    } aext_sel_e;

    typedef logic [3:0] trap_cause_t;

    localparam trap_cause_t CAUSE_LOAD_ACCESS_FAULT      = 4'd5;
    localparam trap_cause_t CAUSE_STORE_AMO_ACCESS_FAULT = 4'd7;

    typedef struct packed {
        mem_sel_e  mem_wen;
        mem_size_e mem_size;
        sign_sel_e sign_sel;
        aext_sel_e a_sel;
    } mem_ctrl_t;

    typedef struct packed {
        logic        valid;
        trap_cause_t cause;
    } trap_info_t;

    typedef struct packed {
        logic      valid;
        logic      wen;
        addr_t     addr;
        uint_x     wdata;
        mem_size_e wmask;
    } cache_req_t;

    typedef struct packed {
        logic  valid;
        logic  error;
        uint_x rdata;
    } cache_resp_t;

endpackage

`default_nettype wire

// ==== mem_stage_fsm.sv ====
`default_nettype none

module mem_stage_fsm (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       valid,
    input  wire                       is_new,
    input  wire mem_pkg::trap_info_t  trapinfo,
    input  wire mem_pkg::mem_ctrl_t   ctrl,
    input  wire mem_pkg::addr_t       alu_out,
    input  wire mem_pkg::uint_x       rs2_data,
    input  wire mem_pkg::uint_x       amo_wdata,
    input  wire mem_pkg::cache_resp_t dresp,
    input  wire                       ready,
    output mem_pkg::cache_req_t       dreq,
    output mem_pkg::uint_x            saved_rdata,
    output logic                      sc_succeeded,
    output mem_pkg::trap_info_t       next_trapinfo,
    output logic                      is_stall
);
    import mem_pkg::*;

    typedef enum logic [1:0] {IDLE, WAIT_READY, WAIT_RVALID, WAIT_WVALID} state_e;

    state_e   state;
    logic     executed;
    mem_sel_e cur_cmd;       // MEN_S during the amo write phase
    addr_t    reserved_addr;
    logic     resp_error;

    logic     done;
    mem_sel_e cmd;
    logic     is_store;
    logic     is_amo_rmw;
    logic     store_class;

    assign done = executed && !is_new;
    assign cmd  = done ? MEN_X : mem_sel_e'(state != IDLE ? cur_cmd : ctrl.mem_wen);

    assign is_store    = cmd == MEN_S || (cmd == MEN_A && ctrl.a_sel == ASEL_SC);
    assign is_amo_rmw  = ctrl.mem_wen == MEN_A && ctrl.a_sel != ASEL_LR && ctrl.a_sel != ASEL_SC;
    assign store_class = !(ctrl.mem_wen == MEN_L || (ctrl.mem_wen == MEN_A && ctrl.a_sel == ASEL_LR));

    assign is_stall = valid && (state != IDLE || cmd != MEN_X);

    always_comb begin
        dreq.valid = state == WAIT_READY && valid && cmd != MEN_X;
        dreq.wen   = is_store;
        dreq.addr  = alu_out;
        dreq.wdata = is_amo_rmw ? amo_wdata : rs2_data;
        dreq.wmask = ctrl.mem_size;
    end

    always_comb begin
        if (ctrl.mem_wen == MEN_X) begin
            next_trapinfo = trapinfo; // not a memory op
        end else begin
            next_trapinfo.valid = resp_error;
            if (!resp_error)
                next_trapinfo.cause = '0;
            else if (store_class)
                next_trapinfo.cause = CAUSE_STORE_AMO_ACCESS_FAULT;
            else
                next_trapinfo.cause = CAUSE_LOAD_ACCESS_FAULT;
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_RVALID && dresp.valid)
            saved_rdata <= dresp.rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            executed      <= 1'b0;
            cur_cmd       <= MEN_X;
            reserved_addr <= ADDR_NONE;
            sc_succeeded  <= 1'b0;
            resp_error    <= 1'b0;
        end else if (!valid) begin
            state    <= IDLE;
            executed <= 1'b0;
            cur_cmd  <= MEN_X;
        end else begin
            if (is_new)
                executed <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd != MEN_X) begin
                        cur_cmd    <= cmd;
                        resp_error <= 1'b0;
                        state      <= WAIT_READY;
                        if (cmd == MEN_A && ctrl.a_sel == ASEL_SC) begin
                            reserved_addr <= ADDR_NONE; // sc always drops it
                            sc_succeeded  <= reserved_addr == alu_out;
                            if (reserved_addr != alu_out) begin
                                state    <= IDLE; // fails without touching memory
                                executed <= 1'b1;
                            end
                        end else if (cmd == MEN_A && ctrl.a_sel == ASEL_LR) begin
                            reserved_addr <= alu_out;
                        end
                    end
                end
                WAIT_READY: begin
                    if (ready)
                        state <= is_store ? WAIT_WVALID : WAIT_RVALID;
                end
                WAIT_RVALID: begin
                    if (dresp.valid) begin
                        resp_error <= dresp.error;
                        if (is_amo_rmw && !dresp.error) begin
                            cur_cmd <= MEN_S; // write back the amo result
                            state   <= WAIT_READY;
                        end else begin
                            state    <= IDLE;
                            executed <= 1'b1;
                        end
                    end
                end
                WAIT_WVALID: begin
                    if (dresp.valid) begin
                        resp_error <= dresp.error;
                        state      <= IDLE;
                        executed   <= 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== amo_alu.sv ====
`default_nettype none

module amo_alu (
    input  wire mem_pkg::aext_sel_e a_sel,
    input  wire mem_pkg::sign_sel_e sign_sel,
    input  wire mem_pkg::uint_x     mem_rdata,
    input  wire mem_pkg::uint_x     rs2_data,
    output mem_pkg::uint_x          wdata
);
    import mem_pkg::*;

    logic mem_lt; // memory value below rs2

    assign mem_lt = (sign_sel == OP_SIGNED) ? ($signed(mem_rdata) < $signed(rs2_data))
                                            : (mem_rdata < rs2_data);

    always_comb begin
        case (a_sel)
            ASEL_AMO_SWAP: wdata = rs2_data;
            ASEL_AMO_ADD:  wdata = mem_rdata + rs2_data;
            ASEL_AMO_XOR:  wdata = mem_rdata ^ rs2_data;
            ASEL_AMO_AND:  wdata = mem_rdata & rs2_data;
            ASEL_AMO_OR:   wdata = mem_rdata | rs2_data;
            ASEL_AMO_MIN:  wdata = mem_lt ? mem_rdata : rs2_data;
            ASEL_AMO_MAX:  wdata = mem_lt ? rs2_data : mem_rdata;
            default:       wdata = rs2_data; // lr and sc never write through here
        endcase
    end

endmodule

`default_nettype wire

// ==== load_format.sv ====
`default_nettype none

module load_format (
    input  wire mem_pkg::mem_ctrl_t ctrl,
    input  wire mem_pkg::uint_x     mem_rdata,
    input  wire                     sc_succeeded,
    output mem_pkg::uint_x          rdata
);
    import mem_pkg::*;

    logic sext_b;
    logic sext_h;

    assign sext_b = ctrl.sign_sel == OP_SIGNED && mem_rdata[7];
    assign sext_h = ctrl.sign_sel == OP_SIGNED && mem_rdata[15];

    always_comb begin
        if (ctrl.mem_wen == MEN_A) begin
            case (ctrl.a_sel)
                ASEL_SC: rdata = sc_succeeded ? '0 : uint_x'(1);
                default: rdata = mem_rdata; // lr and amo return the old word
            endcase
        end else begin
            case (ctrl.mem_size)
                SIZE_B:  rdata = {{(XLEN-8){sext_b}}, mem_rdata[7:0]};
                SIZE_H:  rdata = {{(XLEN-16){sext_h}}, mem_rdata[15:0]};
                default: rdata = mem_rdata;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== stall_counter.sv ====
`default_nettype none

module stall_counter (
    input  wire         clk,
    input  wire         reset,
    input  wire         is_stall,
    output logic [31:0] stall_cycles
);

    always_ff @(posedge clk) begin
        if (reset) begin
            stall_cycles <= '0;
        end else if (is_stall && stall_cycles != '1) begin // hold at max
            stall_cycles <= stall_cycles + 32'd1;
        end
    end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`default_nettype none

module data_mem #(
    parameter int MEM_WORDS = 256,
    parameter int LATENCY   = 2
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mem_pkg::cache_req_t dreq,
    output logic                     ready,
    output mem_pkg::cache_resp_t     dresp
);
    import mem_pkg::*;

    localparam int IW = MEM_WORDS > 1 ? $clog2(MEM_WORDS) : 1;
    localparam int TW = LATENCY > 1 ? $clog2(LATENCY) : 1;

    uint_x mem [MEM_WORDS];

    logic          busy;
    logic [TW-1:0] timer;
    logic          req_wen;
    addr_t         req_addr;
    uint_x         req_wdata;
    mem_size_e     req_size;

    logic          accept;
    logic          fire;      // response cycle
    logic          req_fault;
    logic [IW-1:0] word_idx;
    logic [1:0]    offset;
    logic [3:0]    byte_en;
    uint_x         wdata_sh;

    assign ready     = !busy;
    assign accept    = dreq.valid && ready;
    assign fire      = busy && timer == '0;
    assign req_fault = req_addr >= addr_t'(MEM_WORDS * 4);
    assign word_idx  = req_addr[IW+1:2];
    assign offset    = req_addr[1:0];
    assign wdata_sh  = req_wdata << {offset, 3'b000};

    always_comb begin
        case (req_size)
            SIZE_B:  byte_en = 4'b0001 << offset;
            SIZE_H:  byte_en = 4'b0011 << offset;
            default: byte_en = 4'b1111;
        endcase
    end

    always_comb begin
        dresp.valid = fire;
        dresp.error = req_fault;
        dresp.rdata = req_fault ? '0 : mem[word_idx] >> {offset, 3'b000};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            timer <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            timer <= TW'(LATENCY - 1);
        end else if (fire) begin
            busy <= 1'b0;
        end else if (busy) begin
            timer <= timer - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_wen   <= dreq.wen;
            req_addr  <= dreq.addr;
            req_wdata <= dreq.wdata;
            req_size  <= dreq.wmask;
        end
    end

    // writes land at the end of the response cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < MEM_WORDS; i++)
                mem[i] <= '0;
        end else if (fire && req_wen && !req_fault) begin
            for (int b = 0; b < 4; b++)
                if (byte_en[b])
                    mem[word_idx][b*8 +: 8] <= wdata_sh[b*8 +: 8];
        end
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.sv ====
`default_nettype none

module mem_stage_top #(
    parameter int MEM_WORDS = 256,
    parameter int LATENCY   = 2
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      valid,
    input  wire                      is_new,
    input  wire mem_pkg::trap_info_t trapinfo,
    input  wire mem_pkg::mem_ctrl_t  ctrl,
    input  wire mem_pkg::addr_t      alu_out,
    input  wire mem_pkg::uint_x      rs2_data,
    output mem_pkg::uint_x           next_mem_rdata,
    output mem_pkg::trap_info_t      next_trapinfo,
    output logic                     is_stall,
    output logic [31:0]              stall_cycles
);
    import mem_pkg::*;

    cache_req_t  dreq;
    cache_resp_t dresp;
    logic        ready;
    uint_x       saved_rdata;
    uint_x       amo_wdata;
    logic        sc_succeeded;

    mem_stage_fsm fsm_i (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .is_new        (is_new),
        .trapinfo      (trapinfo),
        .ctrl          (ctrl),
        .alu_out       (alu_out),
        .rs2_data      (rs2_data),
        .amo_wdata     (amo_wdata),
        .dresp         (dresp),
        .ready         (ready),
        .dreq          (dreq),
        .saved_rdata   (saved_rdata),
        .sc_succeeded  (sc_succeeded),
        .next_trapinfo (next_trapinfo),
        .is_stall      (is_stall)
    );

    amo_alu amo_alu_i (
        .a_sel     (ctrl.a_sel),
        .sign_sel  (ctrl.sign_sel),
        .mem_rdata (saved_rdata),
        .rs2_data  (rs2_data),
        .wdata     (amo_wdata)
    );

    load_format load_format_i (
        .ctrl         (ctrl),
        .mem_rdata    (saved_rdata),
        .sc_succeeded (sc_succeeded),
        .rdata        (next_mem_rdata)
    );

    stall_counter stall_counter_i (
        .clk          (clk),
        .reset        (reset),
        .is_stall     (is_stall),
        .stall_cycles (stall_cycles)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS),
        .LATENCY   (LATENCY)
    ) data_mem_i (
        .clk   (clk),
        .reset (reset),
        .dreq  (dreq),
        .ready (ready),
        .dresp (dresp)
    );

endmodule

`default_nettype wire

// ==== tb_mem_stage.sv ====
`default_nettype none

module tb_mem_stage;
    import mem_pkg::*;

    localparam int N_OPS      = 130; // a little above the count issued below
    localparam int MAX_CYCLES = 40 * N_OPS + 20;

    localparam trap_info_t LOAD_FAULT  = '{valid: 1'b1, cause: CAUSE_LOAD_ACCESS_FAULT};
    localparam trap_info_t STORE_FAULT = '{valid: 1'b1, cause: CAUSE_STORE_AMO_ACCESS_FAULT};

    logic        clk;
    logic        reset;
    logic        valid;
    logic        is_new;
    trap_info_t  trapinfo;
    mem_ctrl_t   ctrl;
    addr_t       alu_out;
    uint_x       rs2_data;
    uint_x       next_mem_rdata;
    trap_info_t  next_trapinfo;
    logic        is_stall;
    logic [31:0] stall_cycles;

    logic [7:0]  ref_mem [1024]; // byte image of the memory
    addr_t       ref_res;
    uint_x       exp_rdata;
    trap_info_t  exp_trap;
    logic        exp_check_rdata;
    logic        exp_xop;
    int          n_issued     = 0;
    int          n_done       = 0;
    int          errors       = 0;
    int          final_errors = 0;
    int          cycles       = 0;
    logic [31:0] stall_seen   = '0;
    int          seed         = 32'h4ac7;

    mem_stage_top #(
        .MEM_WORDS (256),
        .LATENCY   (2)
    ) mem_stage_top_i (
        .clk            (clk),
        .reset          (reset),
        .valid          (valid),
        .is_new         (is_new),
        .trapinfo       (trapinfo),
        .ctrl           (ctrl),
        .alu_out        (alu_out),
        .rs2_data       (rs2_data),
        .next_mem_rdata (next_mem_rdata),
        .next_trapinfo  (next_trapinfo),
        .is_stall       (is_stall),
        .stall_cycles   (stall_cycles)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // aligned address somewhere in [base, base+span)
    function automatic addr_t rand_addr(input mem_size_e size, input int base, input int span);
        int off;
        off = rand_below(span);
        if (size == SIZE_H)
            off = off & ~1;
        else if (size == SIZE_W)
            off = off & ~3;
        return addr_t'(base + off);
    endfunction

    function automatic void store_bytes(input addr_t addr, input uint_x data, input int n);
        logic [9:0] idx;
        for (int i = 0; i < n; i++) begin
            idx = addr[9:0] + 10'(i);
            ref_mem[idx] = data[i*8 +: 8];
        end
    endfunction

    function automatic uint_x amo_result(input aext_sel_e asel, input sign_sel_e sign,
                                         input uint_x old, input uint_x rs2);
        logic less;
        less = (sign == OP_SIGNED) ? ($signed(old) < $signed(rs2)) : (old < rs2);
        case (asel)
            ASEL_AMO_ADD: return old + rs2;
            ASEL_AMO_XOR: return old ^ rs2;
            ASEL_AMO_AND: return old & rs2;
            ASEL_AMO_OR:  return old | rs2;
            ASEL_AMO_MIN: return less ? old : rs2;
            ASEL_AMO_MAX: return less ? rs2 : old;
            default:      return rs2; // swap
        endcase
    endfunction

    // returns the expected result of one instruction and updates the model memory and reservation
    function automatic uint_x ref_access(input mem_sel_e sel, input mem_size_e size,
                                         input sign_sel_e sign, input aext_sel_e asel,
                                         input addr_t addr, input uint_x wdata,
                                         input trap_info_t trap_in, output trap_info_t trap);
        logic       fault;
        int         nbytes;
        uint_x      old;
        logic [9:0] idx;
        fault  = addr >= 32'd1024;
        nbytes = (size == SIZE_B) ? 1 : ((size == SIZE_H) ? 2 : 4);
        old    = '0;
        for (int i = 0; i < nbytes; i++) begin
            idx = addr[9:0] + 10'(i);
            if (!fault)
                old[i*8 +: 8] = ref_mem[idx];
        end
        trap = '0;
        case (sel)
            MEN_X: begin
                trap = trap_in;
                return '0;
            end
            MEN_L: begin
                if (fault)
                    trap = LOAD_FAULT;
                if (sign == OP_UNSIGNED || size == SIZE_W)
                    return old;
                if (size == SIZE_B)
                    return {{24{old[7]}}, old[7:0]};
                return {{16{old[15]}}, old[15:0]};
            end
            MEN_S: begin
                if (fault)
                    trap = STORE_FAULT;
                else
                    store_bytes(addr, wdata, nbytes);
                return '0;
            end
            default: begin
                if (asel == ASEL_LR) begin
                    ref_res = addr;
                    if (fault)
                        trap = LOAD_FAULT;
                    return old;
                end
                if (asel == ASEL_SC) begin
                    if (ref_res != addr) begin
                        ref_res = ADDR_NONE;
                        return 32'd1;
                    end
                    ref_res = ADDR_NONE;
                    if (fault)
                        trap = STORE_FAULT;
                    else
                        store_bytes(addr, wdata, 4);
                    return '0;
                end
                if (fault)
                    trap = STORE_FAULT;
                else
                    store_bytes(addr, amo_result(asel, sign, old, wdata), 4);
                return old;
            end
        endcase
    endfunction

    task automatic issue(input mem_sel_e sel, input mem_size_e size, input sign_sel_e sign,
                         input aext_sel_e asel, input addr_t addr, input uint_x wdata,
                         input trap_info_t tin);
        trap_info_t t;
        uint_x      r;
        @(posedge clk);
        valid    <= 1'b1;
        is_new   <= 1'b1;
        ctrl     <= '{mem_wen: sel, mem_size: size, sign_sel: sign, a_sel: asel};
        alu_out  <= addr;
        rs2_data <= wdata;
        trapinfo <= tin;
        r = ref_access(sel, size, sign, asel, addr, wdata, tin, t);
        exp_rdata       = r;
        exp_trap        = t;
        exp_check_rdata = sel != MEN_X && sel != MEN_S && !t.valid; // stores leave rdata stale
        exp_xop         = sel == MEN_X;
        n_issued++;
        @(posedge clk);
        is_new <= 1'b0;
        while (n_done != n_issued)
            @(posedge clk);
    endtask

    // completion is the first negedge with is_stall low
    always @(negedge clk) begin
        if (is_stall)
            stall_seen = stall_seen + 1;
        if (exp_xop && is_stall) begin
            $display("is_stall went high for an instruction without a memory command");
            errors++;
            if (n_done != n_issued)
                n_done++;
        end else if (n_done != n_issued && !is_stall) begin
            if (exp_check_rdata && next_mem_rdata !== exp_rdata) begin
                $display("Error: next_mem_rdata expected %h got %h", exp_rdata,
                         next_mem_rdata);
                errors++;
            end
            if (next_trapinfo !== exp_trap) begin
                $display("Error: next_trapinfo expected %h got %h", exp_trap, next_trapinfo);
                errors++;
            end
            n_done++;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, an instruction never completed", cycles);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        mem_size_e sz;
        addr_t     a;
        reset    = 1'b1;
        valid    = 1'b0;
        is_new   = 1'b0;
        trapinfo = '0;
        ctrl     = '0;
        alu_out  = '0;
        rs2_data = '0;
        ref_res  = ADDR_NONE;
        for (int i = 0; i < 1024; i++)
            ref_mem[i] = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // small window so byte writes overlap
        repeat (60) begin
            sz = mem_size_e'(rand_below(3));
            a  = rand_addr(sz, 0, 32);
            if (rand_below(2) == 0)
                issue(MEN_S, sz, OP_SIGNED, ASEL_LR, a, $random(seed), '0);
            else
                issue(MEN_L, sz, sign_sel_e'(rand_below(2)), ASEL_LR, a, '0, '0);
        end
        issue(MEN_S, SIZE_W, OP_SIGNED, ASEL_LR, 40, 32'h1122_3344, '0);
        issue(MEN_S, SIZE_B, OP_SIGNED, ASEL_LR, 41, 32'h0000_00aa, '0);
        issue(MEN_S, SIZE_H, OP_SIGNED, ASEL_LR, 42, 32'h0000_beef, '0);
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 40, '0, '0);
        issue(MEN_L, SIZE_B, OP_SIGNED, ASEL_LR, 41, '0, '0);

        for (int op = ASEL_AMO_SWAP; op <= ASEL_AMO_MAX; op++) begin
            for (int s = 0; s < 2; s++) begin
                a = rand_addr(SIZE_W, 64, 64);
                issue(MEN_S, SIZE_W, OP_SIGNED, ASEL_LR, a, $random(seed), '0);
                issue(MEN_A, SIZE_W, sign_sel_e'(s), aext_sel_e'(op), a, $random(seed), '0);
                issue(MEN_L, SIZE_W, OP_UNSIGNED, ASEL_LR, a, '0, '0);
            end
        end

        // reservation pairs
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_LR, 128, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC, 128, $random(seed), '0);
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 128, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC, 128, $random(seed), '0);
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 128, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_LR, 128, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC, 132, $random(seed), '0);
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 132, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC, 128, $random(seed), '0);

        // 1024 and up is out of range and aliases words 0 and 1 in the index bits
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 1024, '0, '0);
        issue(MEN_L, SIZE_B, OP_SIGNED, ASEL_LR, 1027, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_LR, 1028, '0, '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_SC, 1028, $random(seed), '0);
        issue(MEN_S, SIZE_W, OP_SIGNED, ASEL_LR, 1024, $random(seed), '0);
        issue(MEN_S, SIZE_B, OP_SIGNED, ASEL_LR, 1030, $random(seed), '0);
        issue(MEN_A, SIZE_W, OP_SIGNED, ASEL_AMO_ADD, 1032, $random(seed), '0);
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 0, '0, '0);
        issue(MEN_L, SIZE_W, OP_SIGNED, ASEL_LR, 4, '0, '0);

        issue(MEN_X, SIZE_W, OP_SIGNED, ASEL_LR, 16, '0, '{valid: 1'b1, cause: 4'd2});
        issue(MEN_X, SIZE_W, OP_SIGNED, ASEL_LR, 2000, '0, '{valid: 1'b1, cause: 4'd11});
        issue(MEN_X, SIZE_W, OP_SIGNED, ASEL_LR, 0, '0, '0);

        @(posedge clk);
        valid <= 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (stall_cycles != stall_seen) begin
            $display("Error: stall_cycles expected %h got %h", stall_seen, stall_cycles);
            final_errors++;
        end
        $display("instructions %0d, mismatches %0d", n_done, errors + final_errors);
        if (errors + final_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
mem_pkg.sv
mem_stage_fsm.sv
amo_alu.sv
load_format.sv
stall_counter.sv
data_mem.sv
mem_stage_top.sv
tb_mem_stage.sv

// ==== Makefile ====
TOP = tb_mem_stage

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --top-module $(TOP) -f sim.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir
